// File: rtl/mipsPkg.sv
`default_nettype none

package mipsPkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  // Data word, PC and byte address
  typedef logic [31:0] word_t;
  // Register number
  typedef logic [4:0]  regAddr_t;
  // Word index into the instruction memory
  typedef logic [7:0]  imemAddr_t;

  // Memory sizes in 32-bit words
  localparam int IMEM_WORDS = 256;
  localparam int DMEM_WORDS = 256;
  // Index width of the data memory
  localparam int DMEM_AW    = $clog2(DMEM_WORDS);

  // First fetch address after reset
  localparam word_t RESET_PC = 32'h0000_0000;

  ////////////////////////////////////////////////////////////
  // Encodings
  ////////////////////////////////////////////////////////////

  // Opcodes, instr[31:26]
  localparam logic [5:0] OP_RTYPE = 6'h00;
  localparam logic [5:0] OP_J     = 6'h02;
  localparam logic [5:0] OP_BEQ   = 6'h04;
  localparam logic [5:0] OP_BNE   = 6'h05;
  localparam logic [5:0] OP_ADDIU = 6'h09;
  localparam logic [5:0] OP_LW    = 6'h23;
  localparam logic [5:0] OP_SW    = 6'h2b;

  // R-type function codes, instr[5:0]
  localparam logic [5:0] FN_ADDU = 6'h21;
  localparam logic [5:0] FN_SUBU = 6'h23;
  localparam logic [5:0] FN_AND  = 6'h24;
  localparam logic [5:0] FN_OR   = 6'h25;
  localparam logic [5:0] FN_SLT  = 6'h2a;

  // ALU operation, decided in decode
  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_SLT
  } aluOp_t;

  // Write-back source
  typedef enum logic {
    WB_ALU,
    WB_MEM
  } wbSel_t;

endpackage

`default_nettype wire

// File: rtl/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
  input  logic              clk,
  input  mipsPkg::regAddr_t rs,
  input  mipsPkg::regAddr_t rt,
  output mipsPkg::word_t    rsData,
  output mipsPkg::word_t    rtData,
  input  logic              we,
  input  mipsPkg::regAddr_t wAddr,
  input  mipsPkg::word_t    wData
);
  import mipsPkg::*;

  word_t regs [32];

  // Register 0 is never stored
  always_ff @(posedge clk) begin
    if (we && (wAddr != '0)) begin
      regs[wAddr] <= wData;
    end
  end

  // Reads see a same-cycle write like a first-half write
  assign rsData = (rs == '0)                  ? '0    :
                  (we && (wAddr == rs))       ? wData : regs[rs];
  assign rtData = (rt == '0)                  ? '0    :
                  (we && (wAddr == rt))       ? wData : regs[rt];

  // Written words read back next cycle and register 0 stays zero
  assert property (@(posedge clk) we |=>
    ((rs != $past(wAddr)) || (we && (wAddr == rs)) ||
     (rsData == (($past(wAddr) == '0) ? '0 : $past(wData)))))
    else $error("regFile: read-back mismatch");

endmodule

`default_nettype wire

// File: rtl/controlUnit.sv
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
  input  mipsPkg::word_t  instr,
  output logic            regWrite,
  output logic            regDstRd,
  output logic            aluSrcImm,
  output mipsPkg::aluOp_t aluOp,
  output logic            memRead,
  output logic            memWrite,
  output mipsPkg::wbSel_t wbSel,
  output logic            branchEq,
  output logic            branchNe,
  output logic            jump,
  output logic            usesRs,
  output logic            usesRt
);
  import mipsPkg::*;

  logic [5:0] opcode;
  logic [5:0] funct;

  assign opcode = instr[31:26];
  assign funct  = instr[5:0];

  always_comb begin
    // Anything unrecognised falls through as a nop
    regWrite  = 1'b0;
    regDstRd  = 1'b0;
    aluSrcImm = 1'b0;
    aluOp     = ALU_ADD;
    memRead   = 1'b0;
    memWrite  = 1'b0;
    wbSel     = WB_ALU;
    branchEq  = 1'b0;
    branchNe  = 1'b0;
    jump      = 1'b0;
    usesRs    = 1'b0;
    usesRt    = 1'b0;
    case (opcode)
      OP_RTYPE: begin
        // ALU control folded in here
        if (funct inside {FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_SLT}) begin
          regWrite = 1'b1;
          regDstRd = 1'b1;
          usesRs   = 1'b1;
          usesRt   = 1'b1;
        end
        case (funct)
          FN_SUBU: aluOp = ALU_SUB;
          FN_AND:  aluOp = ALU_AND;
          FN_OR:   aluOp = ALU_OR;
          FN_SLT:  aluOp = ALU_SLT;
          default: aluOp = ALU_ADD;
        endcase
      end
      OP_ADDIU: begin
        regWrite  = 1'b1;
        aluSrcImm = 1'b1;
        usesRs    = 1'b1;
      end
      OP_LW: begin
        regWrite  = 1'b1;
        aluSrcImm = 1'b1;
        memRead   = 1'b1;
        wbSel     = WB_MEM;
        usesRs    = 1'b1;
      end
      OP_SW: begin
        // Store data comes from rt
        aluSrcImm = 1'b1;
        memWrite  = 1'b1;
        usesRs    = 1'b1;
        usesRt    = 1'b1;
      end
      OP_BEQ, OP_BNE: begin
        branchEq = (opcode == OP_BEQ);
        branchNe = (opcode == OP_BNE);
        usesRs   = 1'b1;
        usesRt   = 1'b1;
      end
      OP_J:    jump = 1'b1;
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/fetchStage.sv
`timescale 1ns/1ps
`default_nettype none

module fetchStage (
  input  logic              clk,
  input  logic              rst,
  input  logic              imemWe,
  input  mipsPkg::imemAddr_t imemAddr,
  input  mipsPkg::word_t    imemData,
  input  logic              stall,
  input  logic              redirect,
  input  mipsPkg::word_t    nextPc,
  output mipsPkg::word_t    idInstr,
  output mipsPkg::word_t    idPc,
  output mipsPkg::word_t    idPcPlus4
);
  import mipsPkg::*;

  word_t     pc;
  word_t     pcPlus4;
  imemAddr_t fetchIdx;
  word_t     imem [IMEM_WORDS];

  // Word index from the byte PC
  assign fetchIdx = pc[$bits(imemAddr_t)+1:2];
  assign pcPlus4  = pc + 32'd4;

  // Program load port, only used while in reset
  always_ff @(posedge clk) begin
    if (imemWe) begin
      imem[imemAddr] <= imemData;
    end
  end

  ////////////////////////////////////////////////////////////
  // PC and IF/ID register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      pc        <= RESET_PC;
      idInstr   <= '0;
      idPc      <= RESET_PC;
      idPcPlus4 <= RESET_PC;
    end else if (!stall) begin
      // Redirect takes the decode target and squashes the wrong-path word
      pc        <= redirect ? nextPc : pcPlus4;
      idInstr   <= redirect ? '0 : imem[fetchIdx];
      idPc      <= pc;
      idPcPlus4 <= pcPlus4;
    end
  end

  // Program may only be placed while the core is held in reset
  assert property (@(posedge clk) imemWe |-> rst)
    else $error("fetchStage: imem write outside reset");

endmodule

`default_nettype wire

// File: rtl/decodeStage.sv
`timescale 1ns/1ps
`default_nettype none

module decodeStage (
  input  logic              clk,
  input  logic              rst,
  input  mipsPkg::word_t    idInstr,
  input  mipsPkg::word_t    idPc,
  input  mipsPkg::word_t    idPcPlus4,
  input  logic              wbValid,
  input  mipsPkg::regAddr_t wbReg,
  input  mipsPkg::word_t    wbData,
  input  logic              exRegWrite,
  input  mipsPkg::regAddr_t exDest,
  input  logic              memRegWrite,
  input  mipsPkg::regAddr_t memDest,
  output logic              stall,
  output logic              redirect,
  output mipsPkg::word_t    nextPc,
  output logic              exCtrlRegWrite,
  output logic              exCtrlRegDstRd,
  output logic              exCtrlAluSrcImm,
  output mipsPkg::aluOp_t   exCtrlAluOp,
  output logic              exCtrlMemRead,
  output logic              exCtrlMemWrite,
  output mipsPkg::wbSel_t   exCtrlWbSel,
  output mipsPkg::word_t    exRsData,
  output mipsPkg::word_t    exRtData,
  output mipsPkg::word_t    exImm,
  output mipsPkg::regAddr_t exRt,
  output mipsPkg::regAddr_t exRd,
  output mipsPkg::word_t    exPc
);
  import mipsPkg::*;

  regAddr_t rs;
  regAddr_t rt;
  regAddr_t rd;
  word_t    imm;
  word_t    rsData;
  word_t    rtData;
  word_t    branchTarget;
  word_t    jumpTarget;
  logic     rsHazard;
  logic     rtHazard;
  logic     branchTaken;

  // Controls for the instruction in decode
  logic     regWrite;
  logic     regDstRd;
  logic     aluSrcImm;
  aluOp_t   aluOp;
  logic     memRead;
  logic     memWrite;
  wbSel_t   wbSel;
  logic     branchEq;
  logic     branchNe;
  logic     jump;
  logic     usesRs;
  logic     usesRt;

  assign rs  = idInstr[25:21];
  assign rt  = idInstr[20:16];
  assign rd  = idInstr[15:11];
  // Sign extension only
  assign imm = {{16{idInstr[15]}}, idInstr[15:0]};

  regFile regFileInst (
    .clk    (clk),
    .rs     (rs),
    .rt     (rt),
    .rsData (rsData),
    .rtData (rtData),
    .we     (wbValid),
    .wAddr  (wbReg),
    .wData  (wbData)
  );

  controlUnit controlUnitInst (
    .instr     (idInstr),
    .regWrite  (regWrite),
    .regDstRd  (regDstRd),
    .aluSrcImm (aluSrcImm),
    .aluOp     (aluOp),
    .memRead   (memRead),
    .memWrite  (memWrite),
    .wbSel     (wbSel),
    .branchEq  (branchEq),
    .branchNe  (branchNe),
    .jump      (jump),
    .usesRs    (usesRs),
    .usesRt    (usesRt)
  );

  ////////////////////////////////////////////////////////////
  // Hazard stall
  ////////////////////////////////////////////////////////////

  // No forwarding, wait until the writer reaches MEM/WB
  assign rsHazard = usesRs && (rs != '0) &&
                    ((exRegWrite && (exDest == rs)) || (memRegWrite && (memDest == rs)));
  assign rtHazard = usesRt && (rt != '0) &&
                    ((exRegWrite && (exDest == rt)) || (memRegWrite && (memDest == rt)));
  assign stall    = rsHazard || rtHazard;

  ////////////////////////////////////////////////////////////
  // Branch and jump resolution
  ////////////////////////////////////////////////////////////

  assign branchTaken  = (branchEq && (rsData == rtData)) ||
                        (branchNe && (rsData != rtData));
  assign branchTarget = idPcPlus4 + {imm[29:0], 2'b00};
  assign jumpTarget   = {idPcPlus4[31:28], idInstr[25:0], 2'b00};

  // Jump wins over branch
  assign nextPc   = jump ? jumpTarget : branchTarget;
  // Operands are stale during a stall, so hold off
  assign redirect = (jump || branchTaken) && !stall;

  ////////////////////////////////////////////////////////////
  // ID/EX register
  ////////////////////////////////////////////////////////////

  // Stall cycles go down the pipe as bubbles
  always_ff @(posedge clk) begin
    if (rst || stall) begin
      exCtrlRegWrite  <= 1'b0;
      exCtrlRegDstRd  <= 1'b0;
      exCtrlAluSrcImm <= 1'b0;
      exCtrlAluOp     <= ALU_ADD;
      exCtrlMemRead   <= 1'b0;
      exCtrlMemWrite  <= 1'b0;
      exCtrlWbSel     <= WB_ALU;
    end else begin
      exCtrlRegWrite  <= regWrite;
      exCtrlRegDstRd  <= regDstRd;
      exCtrlAluSrcImm <= aluSrcImm;
      exCtrlAluOp     <= aluOp;
      exCtrlMemRead   <= memRead;
      exCtrlMemWrite  <= memWrite;
      exCtrlWbSel     <= wbSel;
    end
  end

  // Payload
  always_ff @(posedge clk) begin
    exRsData <= rsData;
    exRtData <= rtData;
    exImm    <= imm;
    exRt     <= rt;
    exRd     <= rd;
    exPc     <= idPc;
  end

  // Never both at once, and the flushed slot behind a redirect is quiet
  assert property (@(posedge clk) disable iff (rst)
    redirect |-> !stall ##1 !(stall || redirect))
    else $error("decodeStage: stall/redirect overlap");

endmodule

`default_nettype wire

// File: rtl/executeStage.sv
`timescale 1ns/1ps
`default_nettype none

module executeStage (
  input  logic              clk,
  input  logic              rst,
  input  logic              exCtrlRegWrite,
  input  logic              exCtrlRegDstRd,
  input  logic              exCtrlAluSrcImm,
  input  mipsPkg::aluOp_t   exCtrlAluOp,
  input  logic              exCtrlMemRead,
  input  logic              exCtrlMemWrite,
  input  mipsPkg::wbSel_t   exCtrlWbSel,
  input  mipsPkg::word_t    exRsData,
  input  mipsPkg::word_t    exRtData,
  input  mipsPkg::word_t    exImm,
  input  mipsPkg::regAddr_t exRt,
  input  mipsPkg::regAddr_t exRd,
  input  mipsPkg::word_t    exPc,
  output mipsPkg::regAddr_t exDest,
  output logic              memRegWrite,
  output mipsPkg::regAddr_t memDest,
  output mipsPkg::word_t    memAluResult,
  output mipsPkg::word_t    memStoreData,
  output logic              memRead,
  output logic              memWrite,
  output mipsPkg::wbSel_t   memWbSel,
  output mipsPkg::word_t    memPc
);
  import mipsPkg::*;

  word_t operandB;
  word_t aluResult;

  assign operandB = exCtrlAluSrcImm ? exImm : exRtData;
  // rd for R-type, rt otherwise; also feeds the hazard check
  assign exDest   = exCtrlRegDstRd ? exRd : exRt;

  always_comb begin
    case (exCtrlAluOp)
      ALU_ADD: aluResult = exRsData + operandB;
      ALU_SUB: aluResult = exRsData - operandB;
      ALU_AND: aluResult = exRsData & operandB;
      ALU_OR:  aluResult = exRsData | operandB;
      // Signed compare
      ALU_SLT: aluResult = {31'b0, $signed(exRsData) < $signed(operandB)};
      default: aluResult = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // EX/MEM register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      memRegWrite <= 1'b0;
      memRead     <= 1'b0;
      memWrite    <= 1'b0;
      memWbSel    <= WB_ALU;
    end else begin
      memRegWrite <= exCtrlRegWrite;
      memRead     <= exCtrlMemRead;
      memWrite    <= exCtrlMemWrite;
      memWbSel    <= exCtrlWbSel;
    end
  end

  always_ff @(posedge clk) begin
    memDest      <= exDest;
    memAluResult <= aluResult;
    memStoreData <= exRtData;
    memPc        <= exPc;
  end

endmodule

`default_nettype wire

// File: rtl/memoryStage.sv
`timescale 1ns/1ps
`default_nettype none

module memoryStage (
  input  logic              clk,
  input  logic              rst,
  input  logic              memRegWrite,
  input  mipsPkg::regAddr_t memDest,
  input  mipsPkg::word_t    memAluResult,
  input  mipsPkg::word_t    memStoreData,
  input  logic              memRead,
  input  logic              memWrite,
  input  mipsPkg::wbSel_t   memWbSel,
  input  mipsPkg::word_t    memPc,
  output logic              wbValid,
  output mipsPkg::regAddr_t wbReg,
  output mipsPkg::word_t    wbData,
  output mipsPkg::word_t    wbPc
);
  import mipsPkg::*;

  logic [DMEM_AW-1:0] dmemIdx;
  word_t              loadData;
  word_t              dmem [DMEM_WORDS];

  // Word accesses only, byte offset dropped
  assign dmemIdx  = memAluResult[DMEM_AW+1:2];
  assign loadData = dmem[dmemIdx];

  always_ff @(posedge clk) begin
    if (memWrite) begin
      dmem[dmemIdx] <= memStoreData;
    end
  end

  ////////////////////////////////////////////////////////////
  // MEM/WB register and report
  ////////////////////////////////////////////////////////////

  // Writes to register 0 are dropped and never reported
  always_ff @(posedge clk) begin
    if (rst) begin
      wbValid <= 1'b0;
    end else begin
      wbValid <= memRegWrite && (memDest != '0);
    end
  end

  always_ff @(posedge clk) begin
    wbReg  <= memDest;
    wbData <= (memWbSel == WB_MEM) ? loadData : memAluResult;
    wbPc   <= memPc;
  end

  // lw and sw must carry a word-aligned address
  assert property (@(posedge clk) disable iff (rst)
    (memRead || memWrite) |-> (memAluResult[1:0] == 2'b00))
    else $error("memoryStage: unaligned access");

endmodule

`default_nettype wire

// File: rtl/mipsCore.sv
`timescale 1ns/1ps
`default_nettype none

module mipsCore (
  input  logic               clk,
  input  logic               rst,
  input  logic               imemWe,
  input  mipsPkg::imemAddr_t imemAddr,
  input  mipsPkg::word_t     imemData,
  output logic               wbValid,
  output mipsPkg::regAddr_t  wbReg,
  output mipsPkg::word_t     wbData,
  output mipsPkg::word_t     wbPc
);
  import mipsPkg::*;

  // IF to ID
  word_t    idInstr;
  word_t    idPc;
  word_t    idPcPlus4;
  logic     stall;
  logic     redirect;
  word_t    nextPc;

  // ID/EX
  logic     exCtrlRegWrite;
  logic     exCtrlRegDstRd;
  logic     exCtrlAluSrcImm;
  aluOp_t   exCtrlAluOp;
  logic     exCtrlMemRead;
  logic     exCtrlMemWrite;
  wbSel_t   exCtrlWbSel;
  word_t    exRsData;
  word_t    exRtData;
  word_t    exImm;
  regAddr_t exRt;
  regAddr_t exRd;
  word_t    exPc;
  regAddr_t exDest;

  // EX/MEM
  logic     memRegWrite;
  regAddr_t memDest;
  word_t    memAluResult;
  word_t    memStoreData;
  logic     memRead;
  logic     memWrite;
  wbSel_t   memWbSel;
  word_t    memPc;

  fetchStage fetchStageInst (
    .clk       (clk),
    .rst       (rst),
    .imemWe    (imemWe),
    .imemAddr  (imemAddr),
    .imemData  (imemData),
    .stall     (stall),
    .redirect  (redirect),
    .nextPc    (nextPc),
    .idInstr   (idInstr),
    .idPc      (idPc),
    .idPcPlus4 (idPcPlus4)
  );

  // Hazard check sees EX via the ID/EX regWrite and the execute dest mux
  decodeStage decodeStageInst (
    .clk             (clk),
    .rst             (rst),
    .idInstr         (idInstr),
    .idPc            (idPc),
    .idPcPlus4       (idPcPlus4),
    .wbValid         (wbValid),
    .wbReg           (wbReg),
    .wbData          (wbData),
    .exRegWrite      (exCtrlRegWrite),
    .exDest          (exDest),
    .memRegWrite     (memRegWrite),
    .memDest         (memDest),
    .stall           (stall),
    .redirect        (redirect),
    .nextPc          (nextPc),
    .exCtrlRegWrite  (exCtrlRegWrite),
    .exCtrlRegDstRd  (exCtrlRegDstRd),
    .exCtrlAluSrcImm (exCtrlAluSrcImm),
    .exCtrlAluOp     (exCtrlAluOp),
    .exCtrlMemRead   (exCtrlMemRead),
    .exCtrlMemWrite  (exCtrlMemWrite),
    .exCtrlWbSel     (exCtrlWbSel),
    .exRsData        (exRsData),
    .exRtData        (exRtData),
    .exImm           (exImm),
    .exRt            (exRt),
    .exRd            (exRd),
    .exPc            (exPc)
  );

  executeStage executeStageInst (
    .clk             (clk),
    .rst             (rst),
    .exCtrlRegWrite  (exCtrlRegWrite),
    .exCtrlRegDstRd  (exCtrlRegDstRd),
    .exCtrlAluSrcImm (exCtrlAluSrcImm),
    .exCtrlAluOp     (exCtrlAluOp),
    .exCtrlMemRead   (exCtrlMemRead),
    .exCtrlMemWrite  (exCtrlMemWrite),
    .exCtrlWbSel     (exCtrlWbSel),
    .exRsData        (exRsData),
    .exRtData        (exRtData),
    .exImm           (exImm),
    .exRt            (exRt),
    .exRd            (exRd),
    .exPc            (exPc),
    .exDest          (exDest),
    .memRegWrite     (memRegWrite),
    .memDest         (memDest),
    .memAluResult    (memAluResult),
    .memStoreData    (memStoreData),
    .memRead         (memRead),
    .memWrite        (memWrite),
    .memWbSel        (memWbSel),
    .memPc           (memPc)
  );

  // Report doubles as the register file write port
  memoryStage memoryStageInst (
    .clk          (clk),
    .rst          (rst),
    .memRegWrite  (memRegWrite),
    .memDest      (memDest),
    .memAluResult (memAluResult),
    .memStoreData (memStoreData),
    .memRead      (memRead),
    .memWrite     (memWrite),
    .memWbSel     (memWbSel),
    .memPc        (memPc),
    .wbValid      (wbValid),
    .wbReg        (wbReg),
    .wbData       (wbData),
    .wbPc         (wbPc)
  );

endmodule

`default_nettype wire

// File: testbench/mipsCoreTb.sv
`timescale 1ns/1ps
`default_nettype none

module mipsCoreTb;
  import mipsPkg::*;

  // MIPS opcodes and function codes, taken from the ISA
  localparam logic [5:0] ENC_SPECIAL = 6'h00;
  localparam logic [5:0] ENC_J       = 6'h02;
  localparam logic [5:0] ENC_BEQ     = 6'h04;
  localparam logic [5:0] ENC_BNE     = 6'h05;
  localparam logic [5:0] ENC_ADDIU   = 6'h09;
  localparam logic [5:0] ENC_LW      = 6'h23;
  localparam logic [5:0] ENC_SW      = 6'h2b;
  localparam logic [5:0] ENC_ADDU    = 6'h21;
  localparam logic [5:0] ENC_SUBU    = 6'h23;
  localparam logic [5:0] ENC_AND     = 6'h24;
  localparam logic [5:0] ENC_OR      = 6'h25;
  localparam logic [5:0] ENC_SLT     = 6'h2a;

  logic      clk;
  logic      rst;
  logic      imemWe;
  imemAddr_t imemAddr;
  word_t     imemData;
  logic      wbValid;
  regAddr_t  wbReg;
  word_t     wbData;
  word_t     wbPc;

  // Program words and the expected write-back reports in order
  word_t    progWords [$];
  word_t    expPc [$];
  regAddr_t expReg [$];
  word_t    expVal [$];

  int rowIdx;
  int errorCount;
  int cycleCount;
  int timeoutLimit;

  mipsCore uut (
    .clk      (clk),
    .rst      (rst),
    .imemWe   (imemWe),
    .imemAddr (imemAddr),
    .imemData (imemData),
    .wbValid  (wbValid),
    .wbReg    (wbReg),
    .wbData   (wbData),
    .wbPc     (wbPc)
  );

  // 8 ns period
  always #4 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Instruction encoders
  ////////////////////////////////////////////////////////////

  function automatic word_t rtypeWord(input int rs, input int rt, input int rd,
                                      input logic [5:0] fn);
    rtypeWord = {ENC_SPECIAL, rs[4:0], rt[4:0], rd[4:0], 5'd0, fn};
  endfunction

  function automatic word_t itypeWord(input logic [5:0] op, input int rs, input int rt,
                                      input int imm);
    itypeWord = {op, rs[4:0], rt[4:0], imm[15:0]};
  endfunction

  // Target given as a byte address
  function automatic word_t jumpWord(input int target);
    jumpWord = {ENC_J, target[27:2]};
  endfunction

  task automatic addInstr(input word_t w);
    progWords.push_back(w);
  endtask

  task automatic addExpect(input int pc, input int rg, input int val);
    expPc.push_back(word_t'(pc));
    expReg.push_back(rg[4:0]);
    expVal.push_back(word_t'(val));
  endtask

  ////////////////////////////////////////////////////////////
  // Program and expected reports
  ////////////////////////////////////////////////////////////

  task automatic buildTables;
    // Arithmetic with sign-extended immediates
    addInstr(itypeWord(ENC_ADDIU, 0, 1, 5));          // 00 r1 = 5
    addInstr(itypeWord(ENC_ADDIU, 0, 2, -3));         // 04 r2 = -3
    addInstr(rtypeWord(1, 2, 3, ENC_ADDU));           // 08 r3 = 2 after a stall on r2
    addInstr(rtypeWord(1, 2, 4, ENC_SUBU));           // 0C r4 = 8
    addInstr(rtypeWord(1, 3, 5, ENC_AND));            // 10 r5 = 0
    addInstr(rtypeWord(1, 3, 6, ENC_OR));             // 14 r6 = 7
    addInstr(rtypeWord(2, 1, 7, ENC_SLT));            // 18 -3 < 5 signed
    addInstr(rtypeWord(1, 2, 8, ENC_SLT));            // 1C 5 < -3 is false
    // Store then load back, then use the load at once
    addInstr(itypeWord(ENC_ADDIU, 0, 9, 32'h40));     // 20 r9 = 0x40
    addInstr(itypeWord(ENC_SW, 9, 6, 4));             // 24 mem[0x44] = r6
    addInstr(itypeWord(ENC_LW, 9, 10, 4));            // 28 r10 = mem[0x44]
    addInstr(rtypeWord(10, 1, 11, ENC_ADDU));         // 2C load-use
    // Taken beq and bne each skip one word
    addInstr(itypeWord(ENC_BEQ, 1, 1, 1));            // 30 to 0x38
    addInstr(itypeWord(ENC_ADDIU, 0, 12, 99));        // 34 skipped
    addInstr(itypeWord(ENC_BNE, 1, 2, 1));            // 38 to 0x40
    addInstr(itypeWord(ENC_ADDIU, 0, 12, 98));        // 3C skipped
    // Not taken
    addInstr(itypeWord(ENC_BEQ, 1, 2, 1));            // 40
    addInstr(itypeWord(ENC_ADDIU, 0, 13, 77));        // 44
    addInstr(itypeWord(ENC_BNE, 1, 1, 1));            // 48
    addInstr(itypeWord(ENC_ADDIU, 0, 14, 66));        // 4C
    addInstr(jumpWord(32'h58));                       // 50
    addInstr(itypeWord(ENC_ADDIU, 0, 15, 55));        // 54 skipped
    // Register 0 swallows the write and still reads zero long after it
    addInstr(itypeWord(ENC_ADDIU, 0, 0, 123));        // 58
    addInstr(itypeWord(ENC_ADDIU, 1, 18, -10));       // 5C r18 = -5
    addInstr(rtypeWord(1, 18, 19, ENC_SUBU));         // 60 r19 = 10 after a stall on r18
    addInstr(rtypeWord(0, 1, 16, ENC_ADDU));          // 64 r16 = 0 + 5
    addInstr(rtypeWord(0, 0, 17, ENC_OR));            // 68 r17 = 0
    addInstr(jumpWord(32'h6C));                       // 6C parks the core

    addExpect(32'h00, 1, 5);
    addExpect(32'h04, 2, 32'hFFFF_FFFD);
    addExpect(32'h08, 3, 2);
    addExpect(32'h0C, 4, 8);
    addExpect(32'h10, 5, 0);
    addExpect(32'h14, 6, 7);
    addExpect(32'h18, 7, 1);
    addExpect(32'h1C, 8, 0);
    addExpect(32'h20, 9, 32'h40);
    addExpect(32'h28, 10, 7);
    addExpect(32'h2C, 11, 12);
    addExpect(32'h44, 13, 77);
    addExpect(32'h4C, 14, 66);
    addExpect(32'h5C, 18, 32'hFFFF_FFFB);
    addExpect(32'h60, 19, 10);
    addExpect(32'h64, 16, 5);
    addExpect(32'h68, 17, 0);
  endtask

  // Closing summary and verdict
  task automatic finishRun;
    if (rowIdx < expPc.size()) begin
      errorCount++;
      $display("Missing write-back reports: only %0d of %0d arrived", rowIdx, expPc.size());
    end
    $display("Errors: %0d, reports checked: %0d of %0d", errorCount, rowIdx, expPc.size());
    if (errorCount == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  initial begin
    clk        = 1'b0;
    rst        = 1'b1;
    imemWe     = 1'b0;
    imemAddr   = '0;
    imemData   = '0;
    rowIdx     = 0;
    errorCount = 0;
    cycleCount = 0;
    buildTables();
    timeoutLimit = 3 * progWords.size() + 50;
    repeat (10) @(posedge clk);
    // One program word per edge while the core is held in reset
    for (int i = 0; i < progWords.size(); i++) begin
      @(posedge clk);
      imemWe   <= 1'b1;
      imemAddr <= imemAddr_t'(i);
      imemData <= progWords[i];
    end
    @(posedge clk);
    imemWe <= 1'b0;
    rst    <= 1'b0;
    while (rowIdx < expPc.size()) begin
      @(posedge clk);
    end
    // Room for any stray report
    repeat (20) @(posedge clk);
    finishRun();
  end

  // Reports compared at the falling edge where outputs are stable
  always @(negedge clk) begin
    if (!rst && wbValid) begin
      if (rowIdx >= expPc.size()) begin
        errorCount++;
        $display("Unexpected write-back report at time %0t: pc %h r%0d = %h",
                 $time, wbPc, wbReg, wbData);
      end else begin
        if (wbPc !== expPc[rowIdx]) begin
          errorCount++;
          $display("CHECK FAILED at time %0t: report %0d pc %h, expected %h",
                   $time, rowIdx, wbPc, expPc[rowIdx]);
        end
        if (wbReg !== expReg[rowIdx]) begin
          errorCount++;
          $display("CHECK FAILED at time %0t: report %0d reg r%0d, expected r%0d",
                   $time, rowIdx, wbReg, expReg[rowIdx]);
        end
        if (wbData !== expVal[rowIdx]) begin
          errorCount++;
          $display("CHECK FAILED at time %0t: report %0d data %h, expected %h",
                   $time, rowIdx, wbData, expVal[rowIdx]);
        end
        rowIdx++;
      end
    end
  end

  // Watchdog counts cycles after reset
  always @(posedge clk) begin
    if (!rst) begin
      cycleCount = cycleCount + 1;
      if (cycleCount > timeoutLimit) begin
        errorCount++;
        $display("Timeout: no progress after %0d cycles out of reset", timeoutLimit);
        finishRun();
      end
    end
  end

endmodule

`default_nettype wire

// File: vlog.f
rtl/mipsPkg.sv
rtl/regFile.sv
rtl/controlUnit.sv
rtl/fetchStage.sv
rtl/decodeStage.sv
rtl/executeStage.sv
rtl/memoryStage.sv
rtl/mipsCore.sv
testbench/mipsCoreTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module mipsCoreTb -f vlog.f -o simv

if ! ./obj_dir/simv > sim.log 2>&1; then
  cat sim.log
  echo "Simulator exited with an error"
  exit 1
fi
cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
  exit 1
fi
